// File: src/la_core_pkg.sv
`default_nettype none

package la_core_pkg;

    localparam int XLEN = 32;
    localparam logic [XLEN-1:0] RESET_PC = 32'h1c00_0000;

    typedef struct packed {
        logic [5:0] op_31_26;
        logic [3:0] op_25_22;
        logic [1:0] op_21_20;
        logic [4:0] op_19_15;
        logic [4:0] rk;
        logic [4:0] rj;
        logic [4:0] rd;
    } inst_reg_fields_s;

    // I26 keeps the low offset half above the high one
    typedef struct packed {
        logic [5:0]  opcode;
        logic [15:0] offs_15_0;
        logic [9:0]  offs_25_16;
    } inst_offs26_fields_s;

    typedef union packed {
        inst_reg_fields_s    reg_fields;
        inst_offs26_fields_s offs26_fields;
    } inst_word_u;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU, ALU_NOR, ALU_AND,
        ALU_OR, ALU_XOR, ALU_SLL, ALU_SRL, ALU_SRA, ALU_LUI
    } alu_op_e;

    typedef enum logic [1:0] {WB_ALU, WB_MEM, WB_LINK} wb_sel_e;

    typedef enum logic [2:0] {BR_NONE, BR_B, BR_BL, BR_JIRL, BR_BEQ, BR_BNE} br_kind_e;

    typedef struct packed {
        alu_op_e         alu_op;
        logic            src1_is_pc;
        logic            src2_is_imm;
        logic [XLEN-1:0] imm;
        logic [XLEN-1:0] br_offs;
        logic [4:0]      rf_raddr1;
        logic [4:0]      rf_raddr2;
        logic [4:0]      dest;
        logic            gr_we;
        logic            mem_rd;
        logic            mem_we;
        br_kind_e        br_kind;
        wb_sel_e         wb_sel;
        logic            illegal;
    } dec_ctrl_s;

    typedef enum logic [2:0] {S_IF, S_ID, S_EXE, S_MEM, S_WB} core_state_e;

    typedef struct packed {
        logic            taken;
        logic [XLEN-1:0] target;
    } br_res_s;

endpackage

`default_nettype wire

// File: src/inst_decoder.sv
`timescale 1ns/100ps
`default_nettype none

module inst_decoder
    import la_core_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       inst_capture,
    input  inst_word_u inst_rdata,
    output dec_ctrl_s  ctrl
);

    inst_word_u       inst_q;
    inst_reg_fields_s f;
    logic [11:0]      i12;
    logic [15:0]      i16;
    logic [19:0]      i20;
    logic [25:0]      i26;

    always_ff @(posedge clk) begin
        if (reset) begin
            inst_q <= '0; // an all-zero word decodes as illegal, so it acts as a no-op
        end else if (inst_capture) begin
            inst_q <= inst_rdata;
        end
    end

    assign f   = inst_q.reg_fields;
    assign i12 = {f.op_21_20, f.op_19_15, f.rk};
    assign i16 = {f.op_25_22, f.op_21_20, f.op_19_15, f.rk};
    assign i20 = {f.op_25_22[2:0], f.op_21_20, f.op_19_15, f.rk, f.rj};
    assign i26 = {inst_q.offs26_fields.offs_25_16, inst_q.offs26_fields.offs_15_0};

    always_comb begin
        ctrl           = '0;
        ctrl.alu_op    = ALU_ADD;
        ctrl.rf_raddr1 = f.rj;
        ctrl.rf_raddr2 = f.rk;
        ctrl.dest      = f.rd;
        ctrl.wb_sel    = WB_ALU;
        ctrl.br_kind   = BR_NONE;
        ctrl.illegal   = 1'b1;
        ctrl.br_offs   = {{14{i16[15]}}, i16, 2'b00};
        case (f.op_31_26)
            6'h00: begin
                ctrl.gr_we = 1'b1;
                if (f.op_25_22 == 4'h0 && f.op_21_20 == 2'h1) begin
                    ctrl.illegal = 1'b0;
                    case (f.op_19_15)
                        5'h00:   ctrl.alu_op = ALU_ADD;
                        5'h02:   ctrl.alu_op = ALU_SUB;
                        5'h04:   ctrl.alu_op = ALU_SLT;
                        5'h05:   ctrl.alu_op = ALU_SLTU;
                        5'h08:   ctrl.alu_op = ALU_NOR;
                        5'h09:   ctrl.alu_op = ALU_AND;
                        5'h0a:   ctrl.alu_op = ALU_OR;
                        5'h0b:   ctrl.alu_op = ALU_XOR;
                        default: ctrl.illegal = 1'b1;
                    endcase
                end else if (f.op_25_22 == 4'h1 && f.op_21_20 == 2'h0) begin
                    ctrl.illegal     = 1'b0;
                    ctrl.src2_is_imm = 1'b1;
                    ctrl.imm         = {27'd0, f.rk}; // ui5 shift amount
                    case (f.op_19_15)
                        5'h01:   ctrl.alu_op = ALU_SLL;
                        5'h09:   ctrl.alu_op = ALU_SRL;
                        5'h11:   ctrl.alu_op = ALU_SRA;
                        default: ctrl.illegal = 1'b1;
                    endcase
                end else if (f.op_25_22 == 4'ha) begin
                    ctrl.illegal     = 1'b0;
                    ctrl.src2_is_imm = 1'b1;
                    ctrl.imm         = {{20{i12[11]}}, i12};
                end
            end
            6'h05: begin
                ctrl.illegal     = f.op_25_22[3];
                ctrl.gr_we       = 1'b1;
                ctrl.alu_op      = ALU_LUI;
                ctrl.src2_is_imm = 1'b1;
                ctrl.imm         = {i20, 12'd0};
            end
            6'h0a: begin
                ctrl.src2_is_imm = 1'b1;
                ctrl.imm         = {{20{i12[11]}}, i12};
                ctrl.rf_raddr2   = f.rd; // store data comes from rd
                if (f.op_25_22 == 4'h2) begin
                    ctrl.illegal = 1'b0;
                    ctrl.gr_we   = 1'b1;
                    ctrl.mem_rd  = 1'b1;
                    ctrl.wb_sel  = WB_MEM;
                end else if (f.op_25_22 == 4'h6) begin
                    ctrl.illegal = 1'b0;
                    ctrl.mem_we  = 1'b1;
                end
            end
            6'h13, 6'h15: begin
                // link value pc + 4 is formed by the ALU
                ctrl.illegal     = 1'b0;
                ctrl.gr_we       = 1'b1;
                ctrl.src1_is_pc  = 1'b1;
                ctrl.src2_is_imm = 1'b1;
                ctrl.imm         = 32'd4;
                ctrl.wb_sel      = WB_LINK;
                if (f.op_31_26 == 6'h15) begin
                    ctrl.br_kind = BR_BL;
                    ctrl.dest    = 5'd1;
                    ctrl.br_offs = {{4{i26[25]}}, i26, 2'b00};
                end else begin
                    ctrl.br_kind = BR_JIRL;
                end
            end
            6'h14: begin
                ctrl.illegal = 1'b0;
                ctrl.br_kind = BR_B;
                ctrl.br_offs = {{4{i26[25]}}, i26, 2'b00};
            end
            6'h16, 6'h17: begin
                ctrl.illegal   = 1'b0;
                ctrl.rf_raddr2 = f.rd;
                ctrl.br_kind   = (f.op_31_26 == 6'h16) ? BR_BEQ : BR_BNE;
            end
            default: ;
        endcase
        if (ctrl.illegal) begin
            ctrl.gr_we   = 1'b0;
            ctrl.mem_we  = 1'b0;
            ctrl.mem_rd  = 1'b0;
            ctrl.br_kind = BR_NONE;
        end
    end

endmodule

`default_nettype wire

// File: src/regfile.sv
`timescale 1ns/100ps
`default_nettype none

module regfile
    import la_core_pkg::*;
(
    input  logic            clk,
    input  logic [4:0]      raddr1,
    input  logic [4:0]      raddr2,
    output logic [XLEN-1:0] rdata1,
    output logic [XLEN-1:0] rdata2,
    input  logic            we,
    input  logic [4:0]      waddr,
    input  logic [XLEN-1:0] wdata
);

    logic [XLEN-1:0] regs [1:31]; // r0 has no storage

    always_ff @(posedge clk) begin
        if (we && waddr != 5'd0) begin
            regs[waddr] <= wdata;
        end
    end

    assign rdata1 = (raddr1 == 5'd0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == 5'd0) ? '0 : regs[raddr2];

endmodule

`default_nettype wire

// File: src/alu.sv
`timescale 1ns/100ps
`default_nettype none

module alu
    import la_core_pkg::*;
(
    input  alu_op_e         op,
    input  logic [XLEN-1:0] src1,
    input  logic [XLEN-1:0] src2,
    output logic [XLEN-1:0] result
);

    logic [4:0] shamt;

    assign shamt = src2[4:0];

    always_comb begin
        case (op)
            ALU_ADD:  result = src1 + src2;
            ALU_SUB:  result = src1 - src2;
            ALU_SLT:  result = {31'd0, $signed(src1) < $signed(src2)};
            ALU_SLTU: result = {31'd0, src1 < src2};
            ALU_NOR:  result = ~(src1 | src2);
            ALU_AND:  result = src1 & src2;
            ALU_OR:   result = src1 | src2;
            ALU_XOR:  result = src1 ^ src2;
            ALU_SLL:  result = src1 << shamt;
            ALU_SRL:  result = src1 >> shamt;
            ALU_SRA:  result = $signed(src1) >>> shamt;
            ALU_LUI:  result = src2; // immediate already shifted by the decoder
            default:  result = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: src/branch_unit.sv
`timescale 1ns/100ps
`default_nettype none

module branch_unit
    import la_core_pkg::*;
(
    input  dec_ctrl_s       ctrl,
    input  logic [XLEN-1:0] pc,
    input  logic [XLEN-1:0] rj_value,
    input  logic [XLEN-1:0] rkd_value,
    output br_res_s         br
);

    logic rj_eq_rd;

    assign rj_eq_rd = (rj_value == rkd_value);

    always_comb begin
        case (ctrl.br_kind)
            BR_B, BR_BL, BR_JIRL: br.taken = 1'b1;
            BR_BEQ:               br.taken = rj_eq_rd;
            BR_BNE:               br.taken = !rj_eq_rd;
            default:              br.taken = 1'b0;
        endcase
        // jirl is the only register-relative target
        br.target = (ctrl.br_kind == BR_JIRL) ? rj_value + ctrl.br_offs
                                              : pc + ctrl.br_offs;
    end

endmodule

`default_nettype wire

// File: src/core_sequencer.sv
`timescale 1ns/100ps
`default_nettype none

module core_sequencer
    import la_core_pkg::*;
(
    input  logic            clk,
    input  logic            reset,
    input  dec_ctrl_s       ctrl,
    input  logic [XLEN-1:0] alu_result,
    input  br_res_s         br,
    input  logic [XLEN-1:0] rkd_value,
    input  logic [XLEN-1:0] data_rdata,
    output logic            inst_capture,
    output logic            rf_we,
    output logic [4:0]      rf_waddr,
    output logic [XLEN-1:0] rf_wdata,
    output logic [XLEN-1:0] pc,
    output logic            inst_sram_en,
    output logic [XLEN-1:0] inst_sram_addr,
    output logic            data_sram_en,
    output logic            data_sram_we,
    output logic [XLEN-1:0] data_sram_addr,
    output logic [XLEN-1:0] data_sram_wdata,
    output logic [XLEN-1:0] debug_wb_pc,
    output logic            debug_wb_rf_we,
    output logic [4:0]      debug_wb_rf_wnum,
    output logic [XLEN-1:0] debug_wb_rf_wdata
);

    core_state_e     state;
    core_state_e     state_next;
    logic [XLEN-1:0] link_q;
    logic [XLEN-1:0] wb_pc_q;

    always_comb begin
        case (state)
            S_IF:  state_next = S_ID;
            S_ID:  state_next = S_EXE;
            S_EXE: begin
                if (ctrl.illegal) begin
                    state_next = S_IF;
                end else if (ctrl.mem_rd || ctrl.mem_we) begin
                    state_next = S_MEM;
                end else if (ctrl.gr_we) begin
                    state_next = S_WB;
                end else begin
                    state_next = S_IF; // b, beq and bne retire here
                end
            end
            S_MEM: state_next = ctrl.mem_rd ? S_WB : S_IF;
            default: state_next = S_IF;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= S_IF;
            pc    <= RESET_PC;
        end else begin
            state <= state_next;
            if (state == S_EXE) begin
                pc <= br.taken ? br.target : pc + 32'd4;
            end
        end
    end

    // pc moves on at the end of EXE, so keep what later states still need
    always_ff @(posedge clk) begin
        if (state == S_EXE) begin
            link_q  <= alu_result;
            wb_pc_q <= pc;
        end
    end

    always_comb begin
        case (ctrl.wb_sel)
            WB_MEM:  rf_wdata = data_rdata;
            WB_LINK: rf_wdata = link_q;
            default: rf_wdata = alu_result;
        endcase
    end

    assign inst_capture    = (state == S_ID);
    assign inst_sram_en    = (state == S_IF);
    assign inst_sram_addr  = pc;
    assign data_sram_en    = (state == S_MEM);
    assign data_sram_we    = data_sram_en && ctrl.mem_we;
    assign data_sram_addr  = alu_result;
    assign data_sram_wdata = rkd_value;
    assign rf_we           = (state == S_WB);
    assign rf_waddr        = ctrl.dest;

    assign debug_wb_pc       = wb_pc_q;
    assign debug_wb_rf_we    = rf_we;
    assign debug_wb_rf_wnum  = rf_waddr;
    assign debug_wb_rf_wdata = rf_wdata;

endmodule

`default_nettype wire

// File: src/la_core_top.sv
`timescale 1ns/100ps
`default_nettype none

module la_core_top
    import la_core_pkg::*;
(
    input  logic            clk,
    input  logic            reset,
    output logic            inst_sram_en,
    output logic [XLEN-1:0] inst_sram_addr,
    input  logic [XLEN-1:0] inst_sram_rdata,
    output logic            data_sram_en,
    output logic            data_sram_we,
    output logic [XLEN-1:0] data_sram_addr,
    output logic [XLEN-1:0] data_sram_wdata,
    input  logic [XLEN-1:0] data_sram_rdata,
    output logic [XLEN-1:0] debug_wb_pc,
    output logic            debug_wb_rf_we,
    output logic [4:0]      debug_wb_rf_wnum,
    output logic [XLEN-1:0] debug_wb_rf_wdata
);

    dec_ctrl_s       ctrl;
    br_res_s         br;
    logic            inst_capture;
    logic            rf_we;
    logic [4:0]      rf_waddr;
    logic [XLEN-1:0] rf_wdata;
    logic [XLEN-1:0] rj_value;
    logic [XLEN-1:0] rkd_value;
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] alu_src1;
    logic [XLEN-1:0] alu_src2;
    logic [XLEN-1:0] alu_result;

    assign alu_src1 = ctrl.src1_is_pc ? pc : rj_value;
    assign alu_src2 = ctrl.src2_is_imm ? ctrl.imm : rkd_value;

    inst_decoder u_inst_decoder (
        .clk          (clk),
        .reset        (reset),
        .inst_capture (inst_capture),
        .inst_rdata   (inst_sram_rdata),
        .ctrl         (ctrl)
    );

    regfile u_regfile (
        .clk    (clk),
        .raddr1 (ctrl.rf_raddr1),
        .raddr2 (ctrl.rf_raddr2),
        .rdata1 (rj_value),
        .rdata2 (rkd_value),
        .we     (rf_we),
        .waddr  (rf_waddr),
        .wdata  (rf_wdata)
    );

    alu u_alu (
        .op     (ctrl.alu_op),
        .src1   (alu_src1),
        .src2   (alu_src2),
        .result (alu_result)
    );

    branch_unit u_branch_unit (
        .ctrl      (ctrl),
        .pc        (pc),
        .rj_value  (rj_value),
        .rkd_value (rkd_value),
        .br        (br)
    );

    core_sequencer u_core_sequencer (
        .clk               (clk),
        .reset             (reset),
        .ctrl              (ctrl),
        .alu_result        (alu_result),
        .br                (br),
        .rkd_value         (rkd_value),
        .data_rdata        (data_sram_rdata),
        .inst_capture      (inst_capture),
        .rf_we             (rf_we),
        .rf_waddr          (rf_waddr),
        .rf_wdata          (rf_wdata),
        .pc                (pc),
        .inst_sram_en      (inst_sram_en),
        .inst_sram_addr    (inst_sram_addr),
        .data_sram_en      (data_sram_en),
        .data_sram_we      (data_sram_we),
        .data_sram_addr    (data_sram_addr),
        .data_sram_wdata   (data_sram_wdata),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_we    (debug_wb_rf_we),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum),
        .debug_wb_rf_wdata (debug_wb_rf_wdata)
    );

endmodule

`default_nettype wire

// File: verification/tb_clock_gen.sv
`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen (
    output logic clk,
    output logic reset
);

    localparam int HALF_PERIOD = 4; // 8 ns clock

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

    initial begin
        reset = 1'b1;
        repeat (2) @(posedge clk);
        reset <= 1'b0;
    end

endmodule

`default_nettype wire

// File: verification/la_core_assertions.sv
`timescale 1ns/100ps
`default_nettype none

module la_core_assertions
    import la_core_pkg::*;
(
    input logic            clk,
    input logic            reset,
    input logic            inst_sram_en,
    input logic            data_sram_en,
    input logic            data_sram_we,
    input logic [XLEN-1:0] data_sram_addr,
    input logic            debug_wb_rf_we
);

    int assert_fail_count = 0; // failed assertions so far

    strobes_exclusive: assert property (@(posedge clk) disable iff (reset)
        !(inst_sram_en && data_sram_en))
        else begin
            $error("instruction and data strobes are high in the same cycle");
            assert_fail_count++;
        end

    wb_single_cycle: assert property (@(posedge clk) disable iff (reset)
        debug_wb_rf_we |=> !debug_wb_rf_we)
        else begin
            $error("trace write enable stays high for more than one cycle");
            assert_fail_count++;
        end

    data_addr_aligned: assert property (@(posedge clk) disable iff (reset)
        data_sram_en |-> data_sram_addr[1:0] == 2'b00)
        else begin
            $error("data access to an address that is not word aligned");
            assert_fail_count++;
        end

    // the core sits in IF right after reset, so only the fetch strobe may be high
    strobes_after_reset: assert property (@(posedge clk)
        reset |=> inst_sram_en && !data_sram_en && !data_sram_we && !debug_wb_rf_we)
        else begin
            $error("strobes are wrong in the cycle after reset");
            assert_fail_count++;
        end

endmodule

bind la_core_top la_core_assertions u_assertions (.*);

`default_nettype wire

// File: verification/tb_la_core.sv
`timescale 1ns/100ps
`default_nettype none

module tb_la_core
    import la_core_pkg::*;
();

    localparam int NUM_INSTS  = 200;
    localparam int LAST_IDX   = NUM_INSTS - 1; // holds b 0
    localparam int MEM_WORDS  = 256;
    localparam int CLK_PERIOD = 8;
    localparam int TIMEOUT_NS = (NUM_INSTS * 5 + 50) * CLK_PERIOD;
    localparam logic [31:0] SEED = 32'h9dc4_14b4;
    localparam logic [16:0] OPS_3R [8] = '{17'h20, 17'h22, 17'h24, 17'h25,
                                            17'h28, 17'h29, 17'h2a, 17'h2b};
    localparam logic [16:0] OPS_SHIFT [3] = '{17'h81, 17'h89, 17'h91};

    typedef struct packed {
        logic [31:0] pc;
        logic [4:0]  num;
        logic [31:0] data;
    } wb_rec_s;

    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] data;
    } st_rec_s;

    logic        clk;
    logic        reset;
    logic        inst_sram_en;
    logic [31:0] inst_sram_addr;
    logic [31:0] inst_sram_rdata;
    logic        data_sram_en;
    logic        data_sram_we;
    logic [31:0] data_sram_addr;
    logic [31:0] data_sram_wdata;
    logic [31:0] data_sram_rdata;
    logic [31:0] debug_wb_pc;
    logic        debug_wb_rf_we;
    logic [4:0]  debug_wb_rf_wnum;
    logic [31:0] debug_wb_rf_wdata;

    logic [31:0] imem [0:MEM_WORDS-1];
    logic [31:0] dmem [0:MEM_WORDS-1];
    logic [31:0] model_gpr [0:31];
    logic [31:0] model_mem [0:MEM_WORDS-1];
    logic [31:0] rng_state;
    wb_rec_s     exp_wb [$];
    st_rec_s     exp_st [$];
    int          wb_idx = 0;
    int          st_idx = 0;
    int          errors = 0;
    int          other_errors = 0;
    int          total;

    tb_clock_gen u_clock_gen (.clk(clk), .reset(reset));

    la_core_top UUT (.*);

    function automatic logic [31:0] next_rand();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    function automatic logic [31:0] fill_word(input logic [31:0] addr);
        return (addr * 32'h0001_0003) ^ 32'h5a5a_c3c3;
    endfunction

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            errors++;
            $display("CHECK FAILED at %0t: %s is %h, expected %h", $time, name, actual, expected);
        end
    endtask

    task automatic build_program();
        logic [31:0] r;
        logic [31:0] r2;
        logic [4:0]  rd;
        logic [4:0]  rj;
        logic [4:0]  rk;
        logic [7:0]  idx;
        logic [7:0]  last_st;
        int          sel;
        int          k;
        int          t;
        last_st = 8'd0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            imem[i] = '0;
        end
        for (int i = 0; i < LAST_IDX; i++) begin
            r   = next_rand();
            r2  = next_rand();
            rd  = {2'b00, r[2:0]}; // only r0..r7 are used so that every source is written first
            rj  = {2'b00, r[5:3]};
            rk  = {2'b00, r[8:6]};
            sel = (i < 7) ? 7 : int'(r[31:28]);
            k   = 1 + int'(r2[21:20]);
            t   = (i + k > LAST_IDX) ? LAST_IDX : i + k;
            k   = t - i;
            idx = r2[0] ? last_st : r2[8:1];
            if (i < 7) rd = 5'(i + 1);
            case (sel)
                4:       imem[i] = {OPS_SHIFT[r2[3:0] % 3], r2[8:4], rj, rd};
                5, 6:    imem[i] = {10'h00a, r2[11:0], rj, rd};
                7:       imem[i] = {7'h0a, r2[19:0], rd};
                8:       imem[i] = {10'h0a2, 2'b00, idx, 2'b00, 5'd0, rd};
                9: begin
                    imem[i] = {10'h0a6, 2'b00, r2[8:1], 2'b00, 5'd0, rd};
                    last_st = r2[8:1];
                end
                10:      imem[i] = {6'h16, 16'(k), rj, rd};
                11:      imem[i] = {6'h17, 16'(k), rj, rd};
                12:      imem[i] = {6'h14, 16'(k), 10'd0};
                13:      imem[i] = {6'h15, 16'(k), 10'd0};
                14:      imem[i] = {6'h13, 16'(t), 5'd0, rd}; // absolute target off r0
                default: imem[i] = {OPS_3R[r2[2:0]], rk, rj, rd};
            endcase
        end
        imem[LAST_IDX] = 32'h5000_0000;
    endtask

    // the model indexes both memories by the word index only
    task automatic run_model();
        logic [31:0] pc;
        logic [31:0] inst;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] val;
        logic [31:0] next_pc;
        logic [31:0] addr;
        logic [31:0] si12;
        logic [31:0] offs16;
        logic [31:0] offs26;
        logic [4:0]  rd;
        logic        wr;
        int          steps;
        pc    = RESET_PC;
        steps = 0;
        for (int i = 0; i < 32; i++) begin
            model_gpr[i] = '0;
        end
        for (int i = 0; i < MEM_WORDS; i++) begin
            model_mem[i] = fill_word(i * 4);
        end
        while (pc[9:2] != LAST_IDX && steps < NUM_INSTS) begin
            inst    = imem[pc[9:2]];
            rd      = inst[4:0];
            a       = model_gpr[inst[9:5]];
            b       = model_gpr[inst[14:10]];
            si12    = {{20{inst[21]}}, inst[21:10]};
            offs16  = {{14{inst[25]}}, inst[25:10], 2'b00};
            offs26  = {{4{inst[9]}}, inst[9:0], inst[25:10], 2'b00};
            addr    = a + si12;
            next_pc = pc + 32'd4;
            wr      = 1'b1;
            val     = '0;
            case (inst[31:26])
                6'h13: begin
                    val     = pc + 32'd4;
                    next_pc = a + offs16;
                end
                6'h14: begin
                    wr      = 1'b0;
                    next_pc = pc + offs26;
                end
                6'h15: begin
                    val     = pc + 32'd4;
                    rd      = 5'd1;
                    next_pc = pc + offs26;
                end
                6'h16, 6'h17: begin
                    wr = 1'b0;
                    if ((a == model_gpr[rd]) == (inst[26] == 1'b0)) next_pc = pc + offs16;
                end
                6'h05: val = {inst[24:5], 12'd0};
                default: begin
                    case (inst[31:22])
                        10'h00a: val = a + si12;
                        10'h0a2: val = model_mem[addr[9:2]];
                        10'h0a6: begin
                            wr = 1'b0;
                            exp_st.push_back('{addr, model_gpr[rd]});
                            model_mem[addr[9:2]] = model_gpr[rd];
                        end
                        default: begin
                            case (inst[31:15])
                                17'h20:  val = a + b;
                                17'h22:  val = a - b;
                                17'h24:  val = {31'd0, $signed(a) < $signed(b)};
                                17'h25:  val = {31'd0, a < b};
                                17'h28:  val = ~(a | b);
                                17'h29:  val = a & b;
                                17'h2a:  val = a | b;
                                17'h2b:  val = a ^ b;
                                17'h81:  val = a << inst[14:10];
                                17'h89:  val = a >> inst[14:10];
                                17'h91:  val = $signed(a) >>> inst[14:10];
                                default: wr = 1'b0;
                            endcase
                        end
                    endcase
                end
            endcase
            if (wr) begin
                exp_wb.push_back('{pc, rd, val});
                if (rd != 5'd0) model_gpr[rd] = val;
            end
            pc = next_pc;
            steps++;
        end
    endtask

    always @(posedge clk) begin
        if (inst_sram_en === 1'b1) inst_sram_rdata <= imem[inst_sram_addr[9:2]];
    end

    always @(posedge clk) begin
        if (data_sram_en === 1'b1) begin
            if (data_sram_we) dmem[data_sram_addr[9:2]] <= data_sram_wdata;
            data_sram_rdata <= dmem[data_sram_addr[9:2]];
        end
    end

    always @(negedge clk) begin
        if (!reset && debug_wb_rf_we === 1'b1) begin
            if (wb_idx < exp_wb.size()) begin
                check_value("debug_wb_pc", debug_wb_pc, exp_wb[wb_idx].pc);
                check_value("debug_wb_rf_wnum", debug_wb_rf_wnum, exp_wb[wb_idx].num);
                check_value("debug_wb_rf_wdata", debug_wb_rf_wdata, exp_wb[wb_idx].data);
            end else begin
                other_errors++;
                $display("at %0t the core wrote a register after the last expected write", $time);
            end
            wb_idx++;
        end
        if (!reset && data_sram_en === 1'b1 && data_sram_we === 1'b1) begin
            if (st_idx < exp_st.size()) begin
                check_value("data_sram_addr", data_sram_addr, exp_st[st_idx].addr);
                check_value("data_sram_wdata", data_sram_wdata, exp_st[st_idx].data);
            end else begin
                other_errors++;
                $display("at %0t the core stored a word after the last expected store", $time);
            end
            st_idx++;
        end
    end

    initial begin
        inst_sram_rdata = '0;
        data_sram_rdata = '0;
        rng_state       = SEED;
        build_program();
        for (int i = 0; i < MEM_WORDS; i++) begin
            dmem[i] = fill_word(i * 4);
        end
        run_model();
        // the fetch of the closing loop means everything before it has retired
        do @(negedge clk); while (!(inst_sram_en === 1'b1 && inst_sram_addr[9:2] == LAST_IDX));
        repeat (2) @(negedge clk);
        check_value("register write count", wb_idx, exp_wb.size());
        check_value("store count", st_idx, exp_st.size());
        total = errors + other_errors + UUT.u_assertions.assert_fail_count;
        $display("errors: %0d mismatches, %0d other, %0d assertion failures",
                 errors, other_errors, UUT.u_assertions.assert_fail_count);
        if (total == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("timeout: the core did not reach the closing loop within %0d ns", TIMEOUT_NS);
        $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: all.f
src/la_core_pkg.sv
src/inst_decoder.sv
src/regfile.sv
src/alu.sv
src/branch_unit.sv
src/core_sequencer.sv
src/la_core_top.sv
verification/tb_clock_gen.sv
verification/la_core_assertions.sv
verification/tb_la_core.sv
